//--- source/mesh_pkg.sv
//----------------------------------------------------------
// mesh package
// geometry, packet and link types for the half ruche
// tile array
//----------------------------------------------------------
`default_nettype none

package mesh_pkg;

  // array geometry
  localparam int num_rows     = 2;
  localparam int num_cols     = 4;
  localparam int ruche_factor = 2;
  localparam int mem_words    = 16;
  localparam int num_dirs     = 7;

  typedef logic [2:0]  x_cord_t;
  typedef logic [0:0]  y_cord_t;
  typedef logic [3:0]  mem_addr_t;
  typedef logic [31:0] data_t;

  typedef enum logic [1:0] {
    op_write = 2'd0,
    op_read  = 2'd1,
    op_rsp   = 2'd2
  } pkt_op_e;

  typedef struct packed {
    pkt_op_e   op;
    x_cord_t   src_x;
    y_cord_t   src_y;
    x_cord_t   dst_x;
    y_cord_t   dst_y;
    mem_addr_t addr;
    data_t     data;
  } mesh_packet_s;

  // forward half of a link, ready travels back on its own
  typedef struct packed {
    logic         valid;
    mesh_packet_s packet;
  } link_fwd_s;

  localparam link_fwd_s link_idle = '0;

  // router port index, P is the local endpoint
  typedef enum logic [2:0] {
    P  = 3'd0,
    W  = 3'd1,
    E  = 3'd2,
    N  = 3'd3,
    S  = 3'd4,
    RW = 3'd5,
    RE = 3'd6
  } dir_e;

endpackage

`default_nettype wire

//--- source/ruche_link_stage.sv
//----------------------------------------------------------
// ruche link stage
// two entry registered slice on one ruche span
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module ruche_link_stage (
  input  logic                  clk_i
  , input  logic                rst_i
  , input  mesh_pkg::link_fwd_s link_i
  , output logic                ready_o
  , output mesh_pkg::link_fwd_s link_o
  , input  logic                ready_i
);

  mesh_pkg::mesh_packet_s entry_q [2];
  logic                   wr_ptr_q;
  logic                   rd_ptr_q;
  logic [1:0]             count_q;
  logic                   push;
  logic                   pop;

  // second entry absorbs the packet in flight when ready drops
  assign ready_o = (count_q < 2'd2);
  assign push = link_i.valid && ready_o;
  assign pop = link_o.valid && ready_i;
  assign link_o = '{valid: (count_q != 2'd0), packet: entry_q[rd_ptr_q]};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q <= 2'd0;
    end else begin
      wr_ptr_q <= wr_ptr_q ^ push;
      rd_ptr_q <= rd_ptr_q ^ pop;
      count_q <= count_q + {1'b0, push} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      entry_q[wr_ptr_q] <= link_i.packet;
    end
  end

  a_max_two: assert property (@(posedge clk_i) disable iff (rst_i) count_q <= 2'd2);

endmodule

`default_nettype wire

//--- source/mesh_router.sv
//----------------------------------------------------------
// mesh router
// seven port dimension order router with half ruche in X
// and one registered output per port
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module mesh_router #(
  parameter mesh_pkg::x_cord_t my_x = 3'd1
  , parameter mesh_pkg::y_cord_t my_y = 1'b0
) (
  input  logic                          clk_i
  , input  logic                        rst_i
  , input  mesh_pkg::link_fwd_s         links_i [mesh_pkg::num_dirs]
  , output logic [mesh_pkg::num_dirs-1:0] links_ready_o
  , output mesh_pkg::link_fwd_s         links_o [mesh_pkg::num_dirs]
  , input  logic [mesh_pkg::num_dirs-1:0] links_ready_i
);

  mesh_pkg::dir_e                want        [mesh_pkg::num_dirs];
  mesh_pkg::dir_e                grant_idx   [mesh_pkg::num_dirs];
  mesh_pkg::dir_e                rr_q        [mesh_pkg::num_dirs];
  logic [mesh_pkg::num_dirs-1:0] grant_valid;
  logic [mesh_pkg::num_dirs-1:0] load;
  logic [mesh_pkg::num_dirs-1:0] out_valid_q;
  mesh_pkg::mesh_packet_s        out_pkt_q   [mesh_pkg::num_dirs];

  // X first, ruche for long hops toward a tile column, then Y
  function automatic mesh_pkg::dir_e route(mesh_pkg::mesh_packet_s pkt);
    int   dx;
    logic x_done;
    logic ruche_ok;
    dx = int'(pkt.dst_x) - int'(my_x);
    // column 1 settles Y before stepping west, so host traffic
    // leaves through the host of its own row
    x_done = (dx == 0) || ((pkt.dst_x == '0) && (my_x == 3'd1) && (pkt.dst_y != my_y));
    ruche_ok = (pkt.dst_x >= 3'd1)
      && ((dx >= mesh_pkg::ruche_factor) || (-dx >= mesh_pkg::ruche_factor));
    if (!x_done) begin
      if (dx > 0) begin
        route = ruche_ok ? mesh_pkg::RE : mesh_pkg::E;
      end else begin
        route = ruche_ok ? mesh_pkg::RW : mesh_pkg::W;
      end
    end else if (pkt.dst_y > my_y) begin
      route = mesh_pkg::S;
    end else if (pkt.dst_y < my_y) begin
      route = mesh_pkg::N;
    end else begin
      route = mesh_pkg::P;
    end
  endfunction

  // round robin per output, search starts after the last winner
  always_comb begin
    int idx;
    idx = 0;
    links_ready_o = '0;
    for (int i = 0; i < mesh_pkg::num_dirs; i++) begin
      want[i] = route(links_i[i].packet);
    end
    for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
      grant_valid[o] = 1'b0;
      grant_idx[o] = mesh_pkg::P;
      for (int k = 1; k <= mesh_pkg::num_dirs; k++) begin
        idx = (int'(rr_q[o]) + k) % mesh_pkg::num_dirs;
        if (!grant_valid[o] && links_i[idx].valid && (want[idx] == mesh_pkg::dir_e'(o))) begin
          grant_valid[o] = 1'b1;
          grant_idx[o] = mesh_pkg::dir_e'(idx);
        end
      end
      // a full register that is not drained takes nothing
      load[o] = grant_valid[o] && (!out_valid_q[o] || links_ready_i[o]);
      if (load[o]) begin
        links_ready_o[grant_idx[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_valid_q <= '0;
      for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
        rr_q[o] <= mesh_pkg::P;
      end
    end else begin
      for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
        if (load[o]) begin
          out_valid_q[o] <= 1'b1;
          rr_q[o] <= grant_idx[o];
        end else if (links_ready_i[o]) begin
          out_valid_q[o] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int o = 0; o < mesh_pkg::num_dirs; o++) begin
      if (load[o]) begin
        out_pkt_q[o] <= links_i[grant_idx[o]].packet;
      end
    end
  end

  for (genvar o = 0; o < mesh_pkg::num_dirs; o++) begin : g_out
    assign links_o[o] = '{valid: out_valid_q[o], packet: out_pkt_q[o]};

    // stalled output holds its packet until the neighbour takes it
    a_out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
      out_valid_q[o] && !links_ready_i[o] |=> out_valid_q[o] && $stable(out_pkt_q[o]));
  end

endmodule

`default_nettype wire

//--- source/tile_endpoint.sv
//----------------------------------------------------------
// tile endpoint
// 16 word memory, stores writes and answers reads with a
// response packet to the requester
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_endpoint #(
  parameter mesh_pkg::x_cord_t my_x = 3'd1
  , parameter mesh_pkg::y_cord_t my_y = 1'b0
) (
  input  logic                  clk_i
  , input  logic                rst_i
  , input  mesh_pkg::link_fwd_s req_i
  , output logic                req_ready_o
  , output mesh_pkg::link_fwd_s rsp_o
  , input  logic                rsp_ready_i
);

  mesh_pkg::data_t        mem_q [mesh_pkg::mem_words];
  logic                   rsp_valid_q;
  mesh_pkg::mesh_packet_s rsp_pkt_q;
  logic                   accept;

  // no new request while a response waits
  assign req_ready_o = !rsp_valid_q;
  assign accept = req_i.valid && req_ready_o;
  assign rsp_o = '{valid: rsp_valid_q, packet: rsp_pkt_q};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rsp_valid_q <= 1'b0;
      rsp_pkt_q <= '0;
      for (int i = 0; i < mesh_pkg::mem_words; i++) begin
        mem_q[i] <= '0;
      end
    end else begin
      if (accept && (req_i.packet.op == mesh_pkg::op_write)) begin
        mem_q[req_i.packet.addr] <= req_i.packet.data;
      end
      if (accept && (req_i.packet.op == mesh_pkg::op_read)) begin
        rsp_valid_q <= 1'b1;
        // response goes back to whoever asked
        rsp_pkt_q <= '{
          op:    mesh_pkg::op_rsp,
          src_x: my_x,
          src_y: my_y,
          dst_x: req_i.packet.src_x,
          dst_y: req_i.packet.src_y,
          addr:  req_i.packet.addr,
          data:  mem_q[req_i.packet.addr]
        };
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // routing upstream must only deliver requests meant for this tile
  a_local_dst: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i.valid |-> (req_i.packet.dst_x == my_x) && (req_i.packet.dst_y == my_y)
      && (req_i.packet.op != mesh_pkg::op_rsp));

endmodule

`default_nettype wire

//--- source/compute_tile.sv
//----------------------------------------------------------
// compute tile
// reset register, router and memory endpoint
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module compute_tile #(
  parameter mesh_pkg::x_cord_t my_x = 3'd1
  , parameter mesh_pkg::y_cord_t my_y = 1'b0
) (
  input  logic                          clk_i
  , input  logic                        rst_i
  , output logic                        rst_o
  , input  mesh_pkg::link_fwd_s         links_i [1:mesh_pkg::num_dirs-1]
  , output logic [mesh_pkg::num_dirs-1:1] links_ready_o
  , output mesh_pkg::link_fwd_s         links_o [1:mesh_pkg::num_dirs-1]
  , input  logic [mesh_pkg::num_dirs-1:1] links_ready_i
);

  logic                          rst_q;
  mesh_pkg::link_fwd_s           rtr_in  [mesh_pkg::num_dirs];
  mesh_pkg::link_fwd_s           rtr_out [mesh_pkg::num_dirs];
  logic [mesh_pkg::num_dirs-1:0] rtr_in_ready;
  logic                          ep_req_ready;

  // one pipeline stage of reset per tile
  always_ff @(posedge clk_i) begin
    rst_q <= rst_i;
  end

  assign rst_o = rst_q;

  for (genvar d = 1; d < mesh_pkg::num_dirs; d++) begin : g_port
    assign rtr_in[d] = links_i[d];
    assign links_o[d] = rtr_out[d];
  end

  assign links_ready_o = rtr_in_ready[mesh_pkg::num_dirs-1:1];

  mesh_router #(
    .my_x(my_x)
    , .my_y(my_y)
  ) router (
    .clk_i(clk_i)
    , .rst_i(rst_q)
    , .links_i(rtr_in)
    , .links_ready_o(rtr_in_ready)
    , .links_o(rtr_out)
    , .links_ready_i({links_ready_i, ep_req_ready})
  );

  tile_endpoint #(
    .my_x(my_x)
    , .my_y(my_y)
  ) endpoint (
    .clk_i(clk_i)
    , .rst_i(rst_q)
    , .req_i(rtr_out[mesh_pkg::P])
    , .req_ready_o(ep_req_ready)
    , .rsp_o(rtr_in[mesh_pkg::P])
    , .rsp_ready_i(rtr_in_ready[mesh_pkg::P])
  );

endmodule

`default_nettype wire

//--- source/tile_array.sv
//----------------------------------------------------------
// tile array
// grid of compute tiles with mesh and half ruche X links,
// host ports on the west edge of each row
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_array (
  input  logic                          clk_i
  , input  logic                        rst_i
  , input  mesh_pkg::link_fwd_s         host_req_i [mesh_pkg::num_rows]
  , output logic [mesh_pkg::num_rows-1:0] host_req_ready_o
  , output mesh_pkg::link_fwd_s         host_rsp_o [mesh_pkg::num_rows]
  , input  logic [mesh_pkg::num_rows-1:0] host_rsp_ready_i
);

  mesh_pkg::link_fwd_s tile_in  [mesh_pkg::num_rows][mesh_pkg::num_cols][1:mesh_pkg::num_dirs-1];
  mesh_pkg::link_fwd_s tile_out [mesh_pkg::num_rows][mesh_pkg::num_cols][1:mesh_pkg::num_dirs-1];
  logic [mesh_pkg::num_dirs-1:1] tile_in_ready  [mesh_pkg::num_rows][mesh_pkg::num_cols];
  logic [mesh_pkg::num_dirs-1:1] tile_out_ready [mesh_pkg::num_rows][mesh_pkg::num_cols];
  logic                          tile_rst       [mesh_pkg::num_rows][mesh_pkg::num_cols];

  for (genvar r = 0; r < mesh_pkg::num_rows; r++) begin : g_row
    for (genvar c = 0; c < mesh_pkg::num_cols; c++) begin : g_col
      logic tile_rst_in;

      // reset ripples down the rows
      if (r == 0) begin : g_rst_top
        assign tile_rst_in = rst_i;
      end else begin : g_rst_chain
        assign tile_rst_in = tile_rst[r-1][c];
      end

      compute_tile #(
        .my_x(mesh_pkg::x_cord_t'(c + 1))
        , .my_y(mesh_pkg::y_cord_t'(r))
      ) tile (
        .clk_i(clk_i)
        , .rst_i(tile_rst_in)
        , .rst_o(tile_rst[r][c])
        , .links_i(tile_in[r][c])
        , .links_ready_o(tile_in_ready[r][c])
        , .links_o(tile_out[r][c])
        , .links_ready_i(tile_out_ready[r][c])
      );

      // west side, host sits left of the first column
      if (c == 0) begin : g_host
        assign tile_in[r][c][mesh_pkg::W] = host_req_i[r];
        assign host_req_ready_o[r] = tile_in_ready[r][c][mesh_pkg::W];
        assign host_rsp_o[r] = tile_out[r][c][mesh_pkg::W];
        assign tile_out_ready[r][c][mesh_pkg::W] = host_rsp_ready_i[r];
      end else begin : g_west
        assign tile_in[r][c][mesh_pkg::W] = tile_out[r][c-1][mesh_pkg::E];
        assign tile_out_ready[r][c][mesh_pkg::W] = tile_in_ready[r][c-1][mesh_pkg::E];
      end

      if (c == mesh_pkg::num_cols - 1) begin : g_east_edge
        assign tile_in[r][c][mesh_pkg::E] = mesh_pkg::link_idle;
        assign tile_out_ready[r][c][mesh_pkg::E] = 1'b1;
      end else begin : g_east
        assign tile_in[r][c][mesh_pkg::E] = tile_out[r][c+1][mesh_pkg::W];
        assign tile_out_ready[r][c][mesh_pkg::E] = tile_in_ready[r][c+1][mesh_pkg::W];
      end

      if (r == 0) begin : g_north_edge
        assign tile_in[r][c][mesh_pkg::N] = mesh_pkg::link_idle;
        assign tile_out_ready[r][c][mesh_pkg::N] = 1'b1;
      end else begin : g_north
        assign tile_in[r][c][mesh_pkg::N] = tile_out[r-1][c][mesh_pkg::S];
        assign tile_out_ready[r][c][mesh_pkg::N] = tile_in_ready[r-1][c][mesh_pkg::S];
      end

      if (r == mesh_pkg::num_rows - 1) begin : g_south_edge
        assign tile_in[r][c][mesh_pkg::S] = mesh_pkg::link_idle;
        assign tile_out_ready[r][c][mesh_pkg::S] = 1'b1;
      end else begin : g_south
        assign tile_in[r][c][mesh_pkg::S] = tile_out[r+1][c][mesh_pkg::N];
        assign tile_out_ready[r][c][mesh_pkg::S] = tile_in_ready[r+1][c][mesh_pkg::N];
      end

      // both directions of the span that ends at this column
      if (c >= mesh_pkg::ruche_factor) begin : g_ruche
        ruche_link_stage east_stage (
          .clk_i(clk_i)
          , .rst_i(tile_rst[r][c])
          , .link_i(tile_out[r][c-mesh_pkg::ruche_factor][mesh_pkg::RE])
          , .ready_o(tile_out_ready[r][c-mesh_pkg::ruche_factor][mesh_pkg::RE])
          , .link_o(tile_in[r][c][mesh_pkg::RW])
          , .ready_i(tile_in_ready[r][c][mesh_pkg::RW])
        );

        ruche_link_stage west_stage (
          .clk_i(clk_i)
          , .rst_i(tile_rst[r][c])
          , .link_i(tile_out[r][c][mesh_pkg::RW])
          , .ready_o(tile_out_ready[r][c][mesh_pkg::RW])
          , .link_o(tile_in[r][c-mesh_pkg::ruche_factor][mesh_pkg::RE])
          , .ready_i(tile_in_ready[r][c-mesh_pkg::ruche_factor][mesh_pkg::RE])
        );
      end else begin : g_ruche_w_edge
        assign tile_in[r][c][mesh_pkg::RW] = mesh_pkg::link_idle;
        assign tile_out_ready[r][c][mesh_pkg::RW] = 1'b1;
      end

      if (c + mesh_pkg::ruche_factor >= mesh_pkg::num_cols) begin : g_ruche_e_edge
        assign tile_in[r][c][mesh_pkg::RE] = mesh_pkg::link_idle;
        assign tile_out_ready[r][c][mesh_pkg::RE] = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/tile_array_checker.sv
//----------------------------------------------------------
// tile array response checker
// matches host responses against expected reads per tile
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_array_checker (
  input  logic                            clk_i
  , input  logic                          rst_i
  , input  logic [mesh_pkg::num_rows-1:0] host_req_ready_i
  , input  mesh_pkg::link_fwd_s           host_rsp_i [mesh_pkg::num_rows]
  , input  logic [mesh_pkg::num_rows-1:0] host_rsp_ready_i
  , input  logic [mesh_pkg::num_rows-1:0] exp_valid_i
  , input  mesh_pkg::mesh_packet_s        exp_pkt_i [mesh_pkg::num_rows]
  , input  logic [2:0]                    test_id_i
  , input  logic                          test_end_i
  , input  logic                          report_i
  , output int                            pending_o
  , output int                            errors_o
);

  mesh_pkg::mesh_packet_s exp_q [$];
  int test_checks;
  int test_errors;
  int total_checks;
  int total_errors;
  int tests_done;

  function automatic string test_name(input logic [2:0] id);
    case (id)
      3'd0: test_name = "reset_zero";
      3'd1: test_name = "write_read";
      3'd2: test_name = "cross_row";
      3'd3: test_name = "random_traffic";
      default: test_name = "final_readback";
    endcase
  endfunction

  // oldest waiting read from the same tile for this host row
  function automatic int find_expected(input mesh_pkg::mesh_packet_s rsp, input int row);
    find_expected = -1;
    for (int i = exp_q.size() - 1; i >= 0; i--) begin
      if ((exp_q[i].src_x == rsp.src_x) && (exp_q[i].src_y == rsp.src_y)
          && (exp_q[i].dst_y == mesh_pkg::y_cord_t'(row))) begin
        find_expected = i;
      end
    end
  endfunction

  always @(posedge clk_i) begin
    int idx;
    if (rst_i) begin
      exp_q.delete();
      test_checks = 0;
      test_errors = 0;
      total_checks = 0;
      total_errors = 0;
      tests_done = 0;
    end else begin
      // a read is expected once its request transfers
      for (int r = 0; r < mesh_pkg::num_rows; r++) begin
        if (exp_valid_i[r] && host_req_ready_i[r]) begin
          exp_q.push_back(exp_pkt_i[r]);
        end
      end
      for (int r = 0; r < mesh_pkg::num_rows; r++) begin
        if (host_rsp_i[r].valid && host_rsp_ready_i[r]) begin
          idx = find_expected(host_rsp_i[r].packet, r);
          test_checks++;
          total_checks++;
          if (idx < 0) begin
            $display("response on row %0d from tile x%0d y%0d arrived with no read waiting",
              r, host_rsp_i[r].packet.src_x, host_rsp_i[r].packet.src_y);
            test_errors++;
            total_errors++;
          end else begin
            if (exp_q[idx] != host_rsp_i[r].packet) begin
              $display("Fail %s: expected %h, actual %h", test_name(test_id_i), exp_q[idx],
                host_rsp_i[r].packet);
              test_errors++;
              total_errors++;
            end
            exp_q.delete(idx);
          end
        end
      end
      if (test_end_i) begin
        $display("%s: %0d checks, %0d errors", test_name(test_id_i), test_checks, test_errors);
        tests_done++;
        test_checks = 0;
        test_errors = 0;
      end
      if (report_i) begin
        $display("tests %0d, checks %0d, errors %0d", tests_done, total_checks, total_errors);
      end
    end
    pending_o = exp_q.size();
    errors_o = total_errors;
  end

endmodule

`default_nettype wire

//--- verification/tile_array_tb.sv
//----------------------------------------------------------
// tile array testbench
// random host traffic per row against a memory model
//----------------------------------------------------------
`timescale 1ns/10ps
`default_nettype none

module tile_array_tb;

  localparam int timeout_cycles = 3000;

  logic                            clk;
  logic                            rst;
  mesh_pkg::link_fwd_s             host_req [mesh_pkg::num_rows];
  logic [mesh_pkg::num_rows-1:0]   host_req_ready;
  mesh_pkg::link_fwd_s             host_rsp [mesh_pkg::num_rows];
  logic [mesh_pkg::num_rows-1:0]   host_rsp_ready;
  logic [mesh_pkg::num_rows-1:0]   exp_valid;
  mesh_pkg::mesh_packet_s          exp_pkt [mesh_pkg::num_rows];
  logic [2:0]                      test_id;
  logic                            test_end;
  logic                            report;
  int                              pending;
  int                              errors;
  integer                          seed = 32'hdb7e;
  mesh_pkg::data_t model [mesh_pkg::num_rows][mesh_pkg::num_cols][mesh_pkg::mem_words];

  tile_array DUT (
    .clk_i(clk)
    , .rst_i(rst)
    , .host_req_i(host_req)
    , .host_req_ready_o(host_req_ready)
    , .host_rsp_o(host_rsp)
    , .host_rsp_ready_i(host_rsp_ready)
  );

  tile_array_checker rsp_check (
    .clk_i(clk)
    , .rst_i(rst)
    , .host_req_ready_i(host_req_ready)
    , .host_rsp_i(host_rsp)
    , .host_rsp_ready_i(host_rsp_ready)
    , .exp_valid_i(exp_valid)
    , .exp_pkt_i(exp_pkt)
    , .test_id_i(test_id)
    , .test_end_i(test_end)
    , .report_i(report)
    , .pending_o(pending)
    , .errors_o(errors)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // host stalls its response port about one cycle in four
  initial begin
    host_rsp_ready = '1;
    forever begin
      @(negedge clk);
      for (int r = 0; r < mesh_pkg::num_rows; r++) begin
        host_rsp_ready[r] = ($random(seed) % 4) != 0;
      end
    end
  end

  task automatic abort_run(input string what);
    $display("timeout: %s", what);
    $display("Verification failed");
    $finish;
  endtask

  // called at a falling edge, returns at the falling edge after the transfer
  task automatic send_pkt(input int row, input mesh_pkg::mesh_packet_s pkt,
                          input logic want_rsp, input mesh_pkg::mesh_packet_s rsp);
    int waited;
    waited = 0;
    host_req[row] = '{valid: 1'b1, packet: pkt};
    exp_valid[row] = want_rsp;
    exp_pkt[row] = rsp;
    @(posedge clk);
    while (!host_req_ready[row]) begin
      waited++;
      if (waited > timeout_cycles) begin
        abort_run("host request was never accepted by the array");
      end
      @(posedge clk);
    end
    @(negedge clk);
    host_req[row].valid = 1'b0;
    exp_valid[row] = 1'b0;
  endtask

  task automatic write_word(input int row, input int ty, input int col,
                            input mesh_pkg::mem_addr_t addr, input mesh_pkg::data_t data);
    mesh_pkg::mesh_packet_s pkt;
    pkt = '{op: mesh_pkg::op_write, src_x: '0, src_y: mesh_pkg::y_cord_t'(row),
      dst_x: mesh_pkg::x_cord_t'(col + 1), dst_y: mesh_pkg::y_cord_t'(ty), addr: addr,
      data: data};
    model[ty][col][addr] = data;
    send_pkt(row, pkt, 1'b0, pkt);
  endtask

  // expected response comes straight from the model
  task automatic read_word(input int row, input int ty, input int col,
                           input mesh_pkg::mem_addr_t addr);
    mesh_pkg::mesh_packet_s req;
    mesh_pkg::mesh_packet_s rsp;
    req = '{op: mesh_pkg::op_read, src_x: '0, src_y: mesh_pkg::y_cord_t'(row),
      dst_x: mesh_pkg::x_cord_t'(col + 1), dst_y: mesh_pkg::y_cord_t'(ty), addr: addr,
      data: '0};
    rsp = '{op: mesh_pkg::op_rsp, src_x: mesh_pkg::x_cord_t'(col + 1),
      src_y: mesh_pkg::y_cord_t'(ty), dst_x: '0, dst_y: mesh_pkg::y_cord_t'(row),
      addr: addr, data: model[ty][col][addr]};
    send_pkt(row, req, 1'b1, rsp);
  endtask

  task automatic write_read_cols(input int row, input int ty);
    int rnd;
    for (int col = 0; col < mesh_pkg::num_cols; col++) begin
      rnd = $random(seed);
      write_word(row, ty, col, rnd[3:0], $random(seed));
      read_word(row, ty, col, rnd[3:0]);
    end
  endtask

  task automatic random_ops(input int row, input int n);
    int rnd;
    int col;
    for (int i = 0; i < n; i++) begin
      rnd = $random(seed);
      col = int'(rnd[9:4]) % mesh_pkg::num_cols;
      if (rnd[12]) begin
        write_word(row, row, col, rnd[3:0], $random(seed));
      end else begin
        read_word(row, row, col, rnd[3:0]);
      end
    end
  endtask

  task automatic readback_row(input int row);
    for (int col = 0; col < mesh_pkg::num_cols; col++) begin
      for (int a = 0; a < mesh_pkg::mem_words; a++) begin
        read_word(row, row, col, mesh_pkg::mem_addr_t'(a));
      end
    end
  endtask

  // wait for every read of the test to come back
  task automatic finish_test();
    int waited;
    waited = 0;
    while (pending != 0) begin
      waited++;
      if (waited > timeout_cycles) begin
        abort_run("expected read responses never came back");
      end
      @(negedge clk);
    end
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
    test_id = test_id + 3'd1;
  endtask

  initial begin
    int rnd;
    rst = 1'b1;
    exp_valid = '0;
    test_id = '0;
    test_end = 1'b0;
    report = 1'b0;
    for (int r = 0; r < mesh_pkg::num_rows; r++) begin
      host_req[r] = mesh_pkg::link_idle;
      exp_pkt[r] = '0;
      for (int c = 0; c < mesh_pkg::num_cols; c++) begin
        for (int a = 0; a < mesh_pkg::mem_words; a++) begin
          model[r][c][a] = '0;
        end
      end
    end
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // reset reaches the last row two cycles late
    repeat (4) @(negedge clk);

    for (int t = 0; t < mesh_pkg::num_rows * mesh_pkg::num_cols; t++) begin
      for (int k = 0; k < 4; k++) begin
        rnd = $random(seed);
        read_word(0, t / mesh_pkg::num_cols, t % mesh_pkg::num_cols, rnd[3:0]);
      end
    end
    finish_test();

    fork
      write_read_cols(0, 0);
      write_read_cols(1, 1);
    join
    finish_test();

    // row 0 host reaches the lower row through N/S links
    write_read_cols(0, 1);
    finish_test();

    fork
      random_ops(0, 120);
      random_ops(1, 120);
    join
    finish_test();

    fork
      readback_row(0);
      readback_row(1);
    join
    finish_test();

    report = 1'b1;
    @(negedge clk);
    report = 1'b0;
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
source/mesh_pkg.sv
source/ruche_link_stage.sv
source/mesh_router.sv
source/tile_endpoint.sv
source/compute_tile.sv
source/tile_array.sv
verification/tile_array_checker.sv
verification/tile_array_tb.sv

//--- Bender.yml
package:
  name: tile_array

sources:
  - source/mesh_pkg.sv
  - source/ruche_link_stage.sv
  - source/mesh_router.sv
  - source/tile_endpoint.sv
  - source/compute_tile.sv
  - source/tile_array.sv
  - target: test
    files:
      - verification/tile_array_checker.sv
      - verification/tile_array_tb.sv
